// File: Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module csr_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module csr_tb -Mdir obj_dir
	./obj_dir/Vcsr_tb | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: rtl/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_DATA_W       32
`define CSR_ADDR_W       14
`define CSR_HWI_N        9
`define CSR_IS_N         13
`define CSR_ECODE_W      6
`define CSR_ESUB_W       9
`define CSR_TIMER_SHIFT  2
`define CSR_TI_BIT       11

// crmd fields
`define CSR_CRMD_PLV     1:0
`define CSR_CRMD_IE      2
`define CSR_CRMD_DA      3
`define CSR_CRMD_PG      4
`define CSR_CRMD_DATF    6:5
`define CSR_CRMD_DATM    8:7

// prmd fields
`define CSR_PRMD_PPLV    1:0
`define CSR_PRMD_PIE     2

`define CSR_ESTAT_SW     1:0

// tcfg and ticlr fields
`define CSR_TCFG_EN      0
`define CSR_TCFG_PERIOD  1
`define CSR_TCFG_INITVAL `CSR_DATA_W-1:`CSR_TIMER_SHIFT
`define CSR_TICLR_CLR    0

`define CSR_EENTRY_ALIGN 6

`endif

// File: rtl/csr_exc_regs.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_exc_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wr_t       wr_i,
    input  logic                   excp_flush_i,
    input  logic                   ertn_flush_i,
    input  csr_pkg::exc_event_t    exc_i,
    input  logic [`CSR_HWI_N-1:0]  hwi_i,
    input  logic                   timer_irq_i,
    output csr_pkg::exc_state_t    state_o,
    output logic                   has_int_o,
    output logic [1:0]             plv_o,
    output logic [`CSR_DATA_W-1:0] eentry_o,
    output logic [`CSR_DATA_W-1:0] era_o
);

    csr_pkg::crmd_t          crmd;
    logic [1:0]              pplv;
    logic                    pie;
    logic [`CSR_IS_N-1:0]    lie;
    logic [1:0]              estat_sw;
    logic [`CSR_HWI_N-1:0]   hwi_q;
    logic [`CSR_ECODE_W-1:0] ecode;
    logic [`CSR_ESUB_W-1:0]  esubcode;
    logic [`CSR_DATA_W-1:0]  era;
    logic [`CSR_DATA_W-`CSR_EENTRY_ALIGN-1:0] eentry_hi;
    logic [`CSR_IS_N-1:0]    is_vec;

    // crmd, exception entry wins over return and writes
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd    <= '0;
            crmd.da <= 1'b1;
        end else if (excp_flush_i) begin
            crmd.plv <= 2'b0;
            crmd.ie  <= 1'b0;
        end else if (ertn_flush_i) begin
            crmd.plv <= pplv;
            crmd.ie  <= pie;
        end else if (wr_i.we && wr_i.addr == csr_pkg::CRMD) begin
            crmd.plv  <= wr_i.data[`CSR_CRMD_PLV];
            crmd.ie   <= wr_i.data[`CSR_CRMD_IE];
            crmd.da   <= wr_i.data[`CSR_CRMD_DA];
            crmd.pg   <= wr_i.data[`CSR_CRMD_PG];
            crmd.datf <= wr_i.data[`CSR_CRMD_DATF];
            crmd.datm <= wr_i.data[`CSR_CRMD_DATM];
        end
    end

    // prmd and ectl
    always_ff @(posedge clk) begin
        if (rst) begin
            pplv <= 2'b0;
            pie  <= 1'b0;
            lie  <= '0;
        end else begin
            if (excp_flush_i) begin
                pplv <= crmd.plv;
                pie  <= crmd.ie;
            end else if (wr_i.we && wr_i.addr == csr_pkg::PRMD) begin
                pplv <= wr_i.data[`CSR_PRMD_PPLV];
                pie  <= wr_i.data[`CSR_PRMD_PIE];
            end
            if (wr_i.we && wr_i.addr == csr_pkg::ECTL) begin
                lie <= wr_i.data[`CSR_IS_N-1:0];
            end
        end
    end

    // estat, era, eentry
    always_ff @(posedge clk) begin
        if (rst) begin
            estat_sw  <= 2'b0;
            hwi_q     <= '0;
            ecode     <= '0;
            esubcode  <= '0;
            era       <= '0;
            eentry_hi <= '0;
        end else begin
            hwi_q <= hwi_i;
            if (excp_flush_i) begin
                ecode    <= exc_i.ecode;
                esubcode <= exc_i.esubcode;
                era      <= exc_i.era;
            end else if (wr_i.we) begin
                if (wr_i.addr == csr_pkg::ESTAT) begin
                    estat_sw <= wr_i.data[`CSR_ESTAT_SW];
                end
                if (wr_i.addr == csr_pkg::ERA) begin
                    era <= wr_i.data;
                end
            end
            if (wr_i.we && wr_i.addr == csr_pkg::EENTRY) begin
                eentry_hi <= wr_i.data[`CSR_DATA_W-1:`CSR_EENTRY_ALIGN];
            end
        end
    end

    // ipi bit unused here
    always_comb begin
        is_vec = '0;
        is_vec[1:0] = estat_sw;
        is_vec[`CSR_TI_BIT-1:2] = hwi_q;
        is_vec[`CSR_TI_BIT] = timer_irq_i;
    end

    assign has_int_o = (|(is_vec & lie)) & crmd.ie;

    assign plv_o = excp_flush_i ? 2'b0 :
                   ertn_flush_i ? pplv : crmd.plv;

    assign eentry_o = {eentry_hi, {`CSR_EENTRY_ALIGN{1'b0}}};
    assign era_o    = era;

    always_comb begin
        state_o          = '0;
        state_o.crmd     = crmd;
        state_o.prmd     = {{(`CSR_DATA_W-3){1'b0}}, pie, pplv};
        state_o.ectl     = {{(`CSR_DATA_W-`CSR_IS_N){1'b0}}, lie};
        state_o.estat_sw = estat_sw;
        state_o.hwi      = hwi_q;
        state_o.ecode    = ecode;
        state_o.esubcode = esubcode;
        state_o.era      = era;
        state_o.eentry   = eentry_o;
    end

endmodule

// File: rtl/csr_pkg.sv
`include "csr_cfg.svh"

package csr_pkg;

    // architectural csr address map
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CRMD   = `CSR_ADDR_W'('h00),
        PRMD   = `CSR_ADDR_W'('h01),
        ECTL   = `CSR_ADDR_W'('h04),
        ESTAT  = `CSR_ADDR_W'('h05),
        ERA    = `CSR_ADDR_W'('h06),
        EENTRY = `CSR_ADDR_W'('h0c),
        SAVE0  = `CSR_ADDR_W'('h30),
        SAVE1  = `CSR_ADDR_W'('h31),
        SAVE2  = `CSR_ADDR_W'('h32),
        SAVE3  = `CSR_ADDR_W'('h33),
        TID    = `CSR_ADDR_W'('h40),
        TCFG   = `CSR_ADDR_W'('h41),
        TVAL   = `CSR_ADDR_W'('h42),
        TICLR  = `CSR_ADDR_W'('h44)
    } csr_addr_e;

    typedef struct packed {
        logic                   we;
        csr_addr_e              addr;
        logic [`CSR_DATA_W-1:0] data;
    } csr_wr_t;

    // lsb at the bottom, matches the register image
    typedef struct packed {
        logic [22:0] zero;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        crmd_t                  crmd;
        logic [`CSR_DATA_W-1:0] prmd;
        logic [`CSR_DATA_W-1:0] ectl;
        logic [1:0]             estat_sw;
        logic [`CSR_HWI_N-1:0]  hwi;
        logic [`CSR_ECODE_W-1:0] ecode;
        logic [`CSR_ESUB_W-1:0] esubcode;
        logic [`CSR_DATA_W-1:0] era;
        logic [`CSR_DATA_W-1:0] eentry;
    } exc_state_t;

    typedef struct packed {
        logic [`CSR_ECODE_W-1:0] ecode;
        logic [`CSR_ESUB_W-1:0]  esubcode;
        logic [`CSR_DATA_W-1:0]  era;
    } exc_event_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] tid;
        logic [`CSR_DATA_W-1:0] tcfg;
        logic [`CSR_DATA_W-1:0] tval;
    } timer_state_t;

endpackage

// File: rtl/csr_read_mux.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_e          raddr_i,
    input  csr_pkg::exc_state_t         exc_i,
    input  csr_pkg::timer_state_t       timer_i,
    input  logic [3:0][`CSR_DATA_W-1:0] save_i,
    input  logic                        timer_irq_i,
    output logic [`CSR_DATA_W-1:0]      rdata_o
);

    logic [`CSR_IS_N-1:0]   is_vec;
    logic [`CSR_DATA_W-1:0] estat;

    always_comb begin
        is_vec = '0;
        is_vec[1:0] = exc_i.estat_sw;
        is_vec[`CSR_TI_BIT-1:2] = exc_i.hwi;
        is_vec[`CSR_TI_BIT] = timer_irq_i;
    end

    // esubcode 30:22, ecode 21:16, is 12:0
    assign estat = {1'b0, exc_i.esubcode, exc_i.ecode, 3'b0, is_vec};

    always_comb begin
        case (raddr_i)
            csr_pkg::CRMD:   rdata_o = exc_i.crmd;
            csr_pkg::PRMD:   rdata_o = exc_i.prmd;
            csr_pkg::ECTL:   rdata_o = exc_i.ectl;
            csr_pkg::ESTAT:  rdata_o = estat;
            csr_pkg::ERA:    rdata_o = exc_i.era;
            csr_pkg::EENTRY: rdata_o = exc_i.eentry;
            csr_pkg::SAVE0:  rdata_o = save_i[0];
            csr_pkg::SAVE1:  rdata_o = save_i[1];
            csr_pkg::SAVE2:  rdata_o = save_i[2];
            csr_pkg::SAVE3:  rdata_o = save_i[3];
            csr_pkg::TID:    rdata_o = timer_i.tid;
            csr_pkg::TCFG:   rdata_o = timer_i.tcfg;
            csr_pkg::TVAL:   rdata_o = timer_i.tval;
            // write-only clear strobe
            csr_pkg::TICLR:  rdata_o = '0;
            default:         rdata_o = '0;
        endcase
    end

endmodule

// File: rtl/csr_save_regs.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_save_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  csr_pkg::csr_wr_t                 wr_i,
    output logic [3:0][`CSR_DATA_W-1:0]      save_o
);

    logic [3:0][`CSR_DATA_W-1:0] save_q;

    // SAVE0..SAVE3 sit at consecutive addresses
    always_ff @(posedge clk) begin
        if (rst) begin
            save_q <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr_i.we && wr_i.addr == csr_pkg::csr_addr_e'(csr_pkg::SAVE0 + i)) begin
                    save_q[i] <= wr_i.data;
                end
            end
        end
    end

    assign save_o = save_q;

endmodule

// File: rtl/csr_timer.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_timer (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wr_t       wr_i,
    output csr_pkg::timer_state_t  state_o,
    output logic                   timer_irq_o,
    output logic [`CSR_DATA_W-1:0] tid_o
);

    logic [`CSR_DATA_W-1:0] tcfg;
    logic [`CSR_DATA_W-1:0] tval;
    logic [`CSR_DATA_W-1:0] tid;
    logic                   timer_en;
    logic                   ti;
    logic                   tcfg_we;
    logic                   ticlr_we;
    logic [`CSR_DATA_W-1:0] reload_val;

    assign tcfg_we  = wr_i.we && wr_i.addr == csr_pkg::TCFG;
    assign ticlr_we = wr_i.we && wr_i.addr == csr_pkg::TICLR;

    // initval scaled by four on every load
    assign reload_val = {tcfg[`CSR_TCFG_INITVAL], {`CSR_TIMER_SHIFT{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg     <= '0;
            tid      <= '0;
            timer_en <= 1'b0;
            ti       <= 1'b0;
        end else begin
            if (tcfg_we) begin
                tcfg <= wr_i.data;
            end
            if (wr_i.we && wr_i.addr == csr_pkg::TID) begin
                tid <= wr_i.data;
            end
            if (ticlr_we && wr_i.data[`CSR_TICLR_CLR]) begin
                ti <= 1'b0;
            end else if (tcfg_we) begin
                timer_en <= wr_i.data[`CSR_TCFG_EN];
            end else if (timer_en && tval == '0) begin
                ti       <= 1'b1;
                timer_en <= tcfg[`CSR_TCFG_PERIOD];
            end
        end
    end

    // countdown, one-shot parks at all ones
    always_ff @(posedge clk) begin
        if (rst) begin
            tval <= '0;
        end else if (tcfg_we) begin
            tval <= {wr_i.data[`CSR_TCFG_INITVAL], {`CSR_TIMER_SHIFT{1'b0}}};
        end else if (timer_en) begin
            if (tval != '0) begin
                tval <= tval - 1'b1;
            end else begin
                tval <= tcfg[`CSR_TCFG_PERIOD] ? reload_val : '1;
            end
        end
    end

    assign timer_irq_o  = ti;
    assign tid_o        = tid;
    assign state_o.tid  = tid;
    assign state_o.tcfg = tcfg;
    assign state_o.tval = tval;

endmodule

// File: rtl/csr_top.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_top (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wr_t       wr1_i,
    input  csr_pkg::csr_wr_t       wr2_i,
    input  logic                   excp_flush_i,
    input  logic                   ertn_flush_i,
    input  csr_pkg::exc_event_t    exc_i,
    input  logic [`CSR_HWI_N-1:0]  hwi_i,
    input  csr_pkg::csr_addr_e     raddr_i,
    output logic [`CSR_DATA_W-1:0] rdata_o,
    output logic                   has_int_o,
    output logic [1:0]             plv_o,
    output logic [`CSR_DATA_W-1:0] eentry_o,
    output logic [`CSR_DATA_W-1:0] era_o,
    output logic [`CSR_DATA_W-1:0] tid_o
);

    csr_pkg::csr_wr_t            wr;
    csr_pkg::exc_state_t         exc_state;
    csr_pkg::timer_state_t       timer_state;
    logic                        timer_irq;
    logic [3:0][`CSR_DATA_W-1:0] save_words;

    // port 1 has fixed priority
    assign wr = wr1_i.we ? wr1_i : wr2_i;

    csr_exc_regs exc_regs_inst (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (wr),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .exc_i        (exc_i),
        .hwi_i        (hwi_i),
        .timer_irq_i  (timer_irq),
        .state_o      (exc_state),
        .has_int_o    (has_int_o),
        .plv_o        (plv_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o)
    );

    csr_timer timer_inst (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr),
        .state_o     (timer_state),
        .timer_irq_o (timer_irq),
        .tid_o       (tid_o)
    );

    csr_save_regs save_regs_inst (
        .clk    (clk),
        .rst    (rst),
        .wr_i   (wr),
        .save_o (save_words)
    );

    csr_read_mux read_mux_inst (
        .raddr_i     (raddr_i),
        .exc_i       (exc_state),
        .timer_i     (timer_state),
        .save_i      (save_words),
        .timer_irq_i (timer_irq),
        .rdata_o     (rdata_o)
    );

endmodule

// File: tb.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_exc_regs.sv
rtl/csr_timer.sv
rtl/csr_save_regs.sv
rtl/csr_read_mux.sv
rtl/csr_top.sv
verification/csr_sva.sv
verification/csr_tb.sv

// File: verification/csr_sva.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  excp_flush_i,
    input logic                  ertn_flush_i,
    input logic                  has_int_o,
    input logic                  timer_irq_i,
    input csr_pkg::exc_state_t   exc_state_i,
    input csr_pkg::timer_state_t timer_state_i
);

    int fail_cnt = 0;

    flush_excl_a: assert property (@(posedge clk) disable iff (rst)
        !(excp_flush_i && ertn_flush_i))
    else begin
        fail_cnt++;
        $error("excp_flush_i and ertn_flush_i are high in the same cycle");
    end

    // ie cleared by exception entry gates the pending output
    int_needs_ie_a: assert property (@(posedge clk) disable iff (rst)
        excp_flush_i |=> !exc_state_i.crmd.ie && !has_int_o)
    else begin
        fail_cnt++;
        $error("CRMD.IE or has_int_o is high after exception entry");
    end

    ti_enabled_a: assert property (@(posedge clk) disable iff (rst)
        $rose(timer_irq_i) |-> $past(timer_state_i.tcfg[`CSR_TCFG_EN]))
    else begin
        fail_cnt++;
        $error("TI was set while the timer was not enabled");
    end

endmodule

bind csr_top csr_sva csr_sva_inst (
    .clk           (clk),
    .rst           (rst),
    .excp_flush_i  (excp_flush_i),
    .ertn_flush_i  (ertn_flush_i),
    .has_int_o     (has_int_o),
    .timer_irq_i   (timer_irq),
    .exc_state_i   (exc_state),
    .timer_state_i (timer_state)
);

// File: verification/csr_tb.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_tb;

    // all tests together stay below 200 cycles, limit leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    logic                   clk;
    logic                   rst;
    csr_pkg::csr_wr_t       wr1_i;
    csr_pkg::csr_wr_t       wr2_i;
    logic                   excp_flush_i;
    logic                   ertn_flush_i;
    csr_pkg::exc_event_t    exc_i;
    logic [`CSR_HWI_N-1:0]  hwi_i;
    csr_pkg::csr_addr_e     raddr_i;
    logic [`CSR_DATA_W-1:0] rdata_o;
    logic                   has_int_o;
    logic [1:0]             plv_o;
    logic [`CSR_DATA_W-1:0] eentry_o;
    logic [`CSR_DATA_W-1:0] era_o;
    logic [`CSR_DATA_W-1:0] tid_o;
    logic [15:0]            lfsr_q;
    int                     cycle_cnt = 0;

    csr_top csr_top_inst (
        .clk          (clk),
        .rst          (rst),
        .wr1_i        (wr1_i),
        .wr2_i        (wr2_i),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .exc_i        (exc_i),
        .hwi_i        (hwi_i),
        .raddr_i      (raddr_i),
        .rdata_o      (rdata_o),
        .has_int_o    (has_int_o),
        .plv_o        (plv_o),
        .eentry_o     (eentry_o),
        .era_o        (era_o),
        .tid_o        (tid_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [`CSR_DATA_W-1:0] rand_bits(input int nbits);
        logic [`CSR_DATA_W-1:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r = {r[`CSR_DATA_W-2:0], lfsr_step()};
        end
        return r;
    endfunction

    task automatic check_word(input string what, input logic [`CSR_DATA_W-1:0] got,
                              input logic [`CSR_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_plv(input string what, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "plv mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // called on a falling edge, returns on the falling edge after the write edge
    task automatic write_csr(input int port, input csr_pkg::csr_addr_e addr,
                             input logic [`CSR_DATA_W-1:0] data);
        if (port == 1) begin
            wr1_i.we = 1'b1;
            wr1_i.addr = addr;
            wr1_i.data = data;
        end else begin
            wr2_i.we = 1'b1;
            wr2_i.addr = addr;
            wr2_i.data = data;
        end
        @(negedge clk);
        wr1_i.we = 1'b0;
        wr2_i.we = 1'b0;
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_e addr,
                            output logic [`CSR_DATA_W-1:0] data);
        raddr_i = addr;
        #1;
        data = rdata_o;
    endtask

    task automatic expect_csr(input csr_pkg::csr_addr_e addr,
                              input logic [`CSR_DATA_W-1:0] exp);
        logic [`CSR_DATA_W-1:0] rd;
        read_csr(addr, rd);
        check_word(addr.name(), rd, exp);
    endtask

    task automatic expect_int(input logic exp);
        #1;
        check_bit("has_int_o", has_int_o, exp);
    endtask

    // TI stays clear until the last of the given cycles
    task automatic check_ti_after(input int cycles);
        logic [`CSR_DATA_W-1:0] rd;
        for (int k = 1; k <= cycles; k++) begin
            @(negedge clk);
            read_csr(csr_pkg::ESTAT, rd);
            check_bit("ESTAT.TI", rd[`CSR_TI_BIT], k == cycles);
        end
    endtask

    task automatic test_reset_values();
        csr_pkg::csr_addr_e zero_addrs [13];
        zero_addrs = '{csr_pkg::PRMD, csr_pkg::ECTL, csr_pkg::ESTAT, csr_pkg::ERA,
                       csr_pkg::EENTRY, csr_pkg::SAVE0, csr_pkg::SAVE1, csr_pkg::SAVE2,
                       csr_pkg::SAVE3, csr_pkg::TID, csr_pkg::TCFG, csr_pkg::TVAL,
                       csr_pkg::TICLR};
        expect_csr(csr_pkg::CRMD, 32'h8);
        for (int i = 0; i < 13; i++) begin
            expect_csr(zero_addrs[i], '0);
        end
        check_bit("has_int_o", has_int_o, 1'b0);
        check_plv("plv_o", plv_o, 2'd0);
    endtask

    task automatic test_write_readback();
        csr_pkg::csr_addr_e     addrs [6];
        logic [`CSR_DATA_W-1:0] exp_w [6];
        logic [`CSR_DATA_W-1:0] d;
        logic [`CSR_DATA_W-1:0] d2;
        addrs = '{csr_pkg::SAVE0, csr_pkg::SAVE1, csr_pkg::SAVE2, csr_pkg::SAVE3,
                  csr_pkg::ERA, csr_pkg::TID};
        for (int i = 0; i < 6; i++) begin
            exp_w[i] = rand_bits(32);
            write_csr(1 + (i % 2), addrs[i], exp_w[i]);
            expect_csr(addrs[i], exp_w[i]);
        end
        check_word("era_o", era_o, exp_w[4]);
        check_word("tid_o", tid_o, exp_w[5]);
        d = rand_bits(32);
        write_csr(2, csr_pkg::EENTRY, d);
        expect_csr(csr_pkg::EENTRY, {d[`CSR_DATA_W-1:6], 6'b0});
        check_word("eentry_o", eentry_o, {d[`CSR_DATA_W-1:6], 6'b0});
        // both ports in one cycle, port 2 is dropped
        d = rand_bits(32);
        d2 = rand_bits(32);
        wr2_i = '{we: 1'b1, addr: csr_pkg::SAVE3, data: d2};
        write_csr(1, csr_pkg::SAVE2, d);
        expect_csr(csr_pkg::SAVE2, d);
        expect_csr(csr_pkg::SAVE3, exp_w[3]);
    endtask

    task automatic test_exception();
        logic [`CSR_DATA_W-1:0] r;
        logic [`CSR_ECODE_W-1:0] ecode;
        logic [`CSR_ESUB_W-1:0]  esub;
        logic [`CSR_DATA_W-1:0] era;
        r = rand_bits(6);
        ecode = r[`CSR_ECODE_W-1:0];
        r = rand_bits(9);
        esub = r[`CSR_ESUB_W-1:0];
        era = rand_bits(32);
        // plv 3, ie 1, da 1
        write_csr(1, csr_pkg::CRMD, 32'hf);
        exc_i = '{ecode: ecode, esubcode: esub, era: era};
        excp_flush_i = 1'b1;
        #1;
        check_plv("plv_o during exception", plv_o, 2'd0);
        @(negedge clk);
        excp_flush_i = 1'b0;
        expect_csr(csr_pkg::CRMD, 32'h8);
        expect_csr(csr_pkg::PRMD, 32'h7);
        expect_csr(csr_pkg::ESTAT, {1'b0, esub, ecode, 3'b000, {`CSR_IS_N{1'b0}}});
        expect_csr(csr_pkg::ERA, era);
        check_word("era_o", era_o, era);
        check_plv("plv_o after exception", plv_o, 2'd0);
        ertn_flush_i = 1'b1;
        #1;
        check_plv("plv_o during return", plv_o, 2'd3);
        @(negedge clk);
        ertn_flush_i = 1'b0;
        expect_csr(csr_pkg::CRMD, 32'hf);
        check_plv("plv_o after return", plv_o, 2'd3);
        write_csr(2, csr_pkg::CRMD, 32'h8);
    endtask

    task automatic test_oneshot_timer();
        logic [`CSR_DATA_W-1:0] r;
        int n;
        r = rand_bits(3);
        n = 3 + int'(r[2:0]);
        write_csr(1, csr_pkg::TCFG, (n << 2) | 1);
        check_ti_after(4 * n + 1);
        check_ti_after(1);
        expect_csr(csr_pkg::TVAL, '1);
        expect_csr(csr_pkg::TCFG, (n << 2) | 1);
        write_csr(2, csr_pkg::TICLR, 32'h1);
        read_csr(csr_pkg::ESTAT, r);
        check_bit("ESTAT.TI after clear", r[`CSR_TI_BIT], 1'b0);
        expect_csr(csr_pkg::TVAL, '1);
    endtask

    task automatic test_periodic_timer();
        logic [`CSR_DATA_W-1:0] r;
        int n;
        r = rand_bits(3);
        n = 3 + int'(r[2:0]);
        write_csr(1, csr_pkg::TCFG, (n << 2) | 3);
        check_ti_after(4 * n + 1);
        // the clear edge is one cycle after TI set
        write_csr(1, csr_pkg::TICLR, 32'h1);
        check_ti_after(4 * n);
        write_csr(2, csr_pkg::TCFG, '0);
        write_csr(2, csr_pkg::TICLR, 32'h1);
    endtask

    task automatic test_interrupt_pending();
        logic [`CSR_DATA_W-1:0] r;
        logic [`CSR_DATA_W-1:0] lie;
        int j;
        r = rand_bits(4);
        j = int'(r % 9);
        lie = '0;
        lie[j + 2] = 1'b1;
        hwi_i[j] = 1'b1;
        @(negedge clk);
        expect_int(1'b0);
        read_csr(csr_pkg::ESTAT, r);
        check_bit("ESTAT.IS hardware bit", r[j + 2], 1'b1);
        write_csr(1, csr_pkg::ECTL, lie);
        expect_int(1'b0);
        write_csr(1, csr_pkg::CRMD, 32'hc);
        expect_int(1'b1);
        hwi_i = '0;
        @(negedge clk);
        expect_int(1'b0);
        hwi_i[j] = 1'b1;
        @(negedge clk);
        expect_int(1'b1);
        write_csr(2, csr_pkg::ECTL, '0);
        expect_int(1'b0);
        write_csr(2, csr_pkg::ECTL, lie);
        write_csr(1, csr_pkg::CRMD, 32'h8);
        expect_int(1'b0);
        hwi_i = '0;
        // timer source on IS bit 11
        lie = '0;
        lie[`CSR_TI_BIT] = 1'b1;
        write_csr(1, csr_pkg::ECTL, lie);
        write_csr(1, csr_pkg::CRMD, 32'hc);
        expect_int(1'b0);
        write_csr(1, csr_pkg::TCFG, 32'h5);
        check_ti_after(5);
        expect_int(1'b1);
        write_csr(2, csr_pkg::CRMD, 32'h8);
        expect_int(1'b0);
        write_csr(2, csr_pkg::CRMD, 32'hc);
        expect_int(1'b1);
        write_csr(1, csr_pkg::ECTL, '0);
        expect_int(1'b0);
        write_csr(1, csr_pkg::ECTL, lie);
        expect_int(1'b1);
        write_csr(2, csr_pkg::TICLR, 32'h1);
        expect_int(1'b0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        wr1_i = '0;
        wr2_i = '0;
        excp_flush_i = 1'b0;
        ertn_flush_i = 1'b0;
        exc_i = '0;
        hwi_i = '0;
        raddr_i = csr_pkg::CRMD;
        lfsr_q = 16'd21456;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_reset_values();
        test_write_readback();
        test_exception();
        test_oneshot_timer();
        test_periodic_timer();
        test_interrupt_pending();
        if (csr_top_inst.csr_sva_inst.fail_cnt == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "assertion failures were reported");
        end
    end

endmodule
